// File: id_remap.f
+incdir+.
id_remap_pkg.sv
id_remap_table.sv
id_remap_dir.sv
id_remap_top.sv
tb_clk_gen.sv
tb_id_remap.sv

// File: id_remap_defs.svh
// Width and size macros for the ID remapper, included by the package, the RTL and the testbench.
`ifndef ID_REMAP_DEFS_SVH
`define ID_REMAP_DEFS_SVH

// Width of a transaction ID at the upstream port.
// It must be at least 1 bit wide.
`define IN_ID_W 6

// Number of remap table entries, which is also the number of distinct output IDs.
// It must be at least 1 and at most 2**IN_ID_W.
`define MAX_UNIQ_IDS 4

// Width of a table index and of the downstream ID.
// It must equal the ceiled binary logarithm of MAX_UNIQ_IDS, with a minimum of 1.
`define OUT_ID_W 2

// In-flight limit for one ID.
// It must be at least 1.
`define MAX_TXNS_PER_ID 3

// Counter width.
// It must be wide enough to hold MAX_TXNS_PER_ID.
`define CNT_W 2

// Payload field widths, identical on both sides of the remapper.
`define ADDR_W 32
`define DATA_W 32
`define LEN_W 8

`endif

// File: id_remap_dir.sv
// Remap controller for one direction (AR/R or AW/B); admits requests and restores response IDs.
`default_nettype none

module id_remap_dir #(
  // Set for reads, where only the last beat of a burst retires the entry.
  parameter bit RspHasLast = 1'b1
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Upstream request channel.
  input  wire id_remap_pkg::ax_up_t    up_req_i,
  input  wire logic                    up_valid_i,
  output logic                         up_ready_o,
  // Downstream request channel.
  output id_remap_pkg::ax_dn_t         dn_req_o,
  output logic                         dn_valid_o,
  input  wire logic                    dn_ready_i,
  // Response handshake as seen on both sides, plus the ID it carries downstream.
  input  wire id_remap_pkg::out_id_t   dn_rsp_id_i,
  input  wire logic                    dn_rsp_valid_i,
  input  wire logic                    rsp_ready_i,
  input  wire logic                    rsp_last_i,
  // Restored upstream response ID.
  output id_remap_pkg::in_id_t         up_rsp_id_o
);

  import id_remap_pkg::*;

  // Idle decides admission for a new request.
  // Hold replays an accepted-into-table request until downstream takes it.
  typedef enum logic {
    Idle,
    Hold
  } state_e;

  state_e  state_q;
  state_e  state_d;

  // Output ID of a request waiting in the hold state.
  out_id_t held_id_q;
  out_id_t held_id_d;

  // Table interface.
  out_id_t free_id;
  logic    full;
  logic    hit;
  out_id_t hit_id;
  logic    hit_full;
  logic    push;
  logic    pop;
  out_id_t out_id;

  // A response retires its entry once it has transferred upstream.
  // For reads this only happens on the final beat.
  assign pop = dn_rsp_valid_i && rsp_ready_i && (!RspHasLast || rsp_last_i);

  id_remap_table u_table (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .free_id_o     ( free_id     ),
    .full_o        ( full        ),
    .lookup_id_i   ( up_req_i.id ),
    .hit_o         ( hit         ),
    .hit_id_o      ( hit_id      ),
    .hit_full_o    ( hit_full    ),
    .push_i        ( push        ),
    .push_in_id_i  ( up_req_i.id ),
    .push_out_id_i ( out_id      ),
    .pop_i         ( pop         ),
    .pop_out_id_i  ( dn_rsp_id_i ),
    .pop_in_id_o   ( up_rsp_id_o )
  );

  // Upstream keeps the payload stable while it waits, so only the ID is replaced.
  assign dn_req_o.id   = out_id;
  assign dn_req_o.addr = up_req_i.addr;
  assign dn_req_o.len  = up_req_i.len;

  always_comb begin
    state_d    = state_q;
    held_id_d  = held_id_q;
    dn_valid_o = 1'b0;
    up_ready_o = 1'b0;
    push       = 1'b0;
    out_id     = '0;

    unique case (state_q)
      Idle: begin
        // A request with an in-flight ID must reuse that output ID to keep its order.
        // A new ID takes the lowest free entry instead.
        out_id = hit ? hit_id : free_id;
        if (up_valid_i && (hit ? !hit_full : !full)) begin
          dn_valid_o = 1'b1;
          up_ready_o = dn_ready_i;
          // The entry is claimed now, whether or not downstream takes the request yet.
          push       = 1'b1;
          if (!dn_ready_i) begin
            held_id_d = out_id;
            state_d   = Hold;
          end
        end
      end

      Hold: begin
        // No second push here; the table already counts this request.
        out_id     = held_id_q;
        dn_valid_o = 1'b1;
        up_ready_o = dn_ready_i;
        if (dn_ready_i) begin
          state_d = Idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    held_id_q <= held_id_d;
  end

  // AXI requires a pending request to stay put, ID included, until it is taken.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      dn_valid_o && !dn_ready_i |=> dn_valid_o && $stable(dn_req_o.id))
    else $error("Held downstream request dropped valid or changed its ID.");

  // A request is taken from upstream exactly when it leaves downstream.
  // In the hold state this also relies on upstream keeping its valid high.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      (up_valid_i && up_ready_o) == (dn_valid_o && dn_ready_i))
    else $error("Upstream and downstream request transfers are not paired.");

endmodule

`default_nettype wire

// File: id_remap_pkg.sv
// Shared types of the ID remapper: IDs, table entries and the AXI channel payload structs.
`default_nettype none

`include "id_remap_defs.svh"

package id_remap_pkg;

  // An ID as seen at the upstream port.
  typedef logic [`IN_ID_W-1:0] in_id_t;
  // An ID as seen downstream, which doubles as the table index.
  typedef logic [`OUT_ID_W-1:0] out_id_t;
  // Number of transactions in flight on one entry.
  typedef logic [`CNT_W-1:0] cnt_t;
  // One bit per table entry.
  typedef logic [`MAX_UNIQ_IDS-1:0] field_t;

  // One table entry.
  // A zero count marks the entry as free, and its input ID is then meaningless.
  typedef struct packed {
    in_id_t in_id;
    cnt_t   cnt;
  } entry_t;

  // AR or AW request on the upstream side.
  typedef struct packed {
    in_id_t              id;
    logic [`ADDR_W-1:0]  addr;
    logic [`LEN_W-1:0]   len;
  } ax_up_t;

  // AR or AW request on the downstream side, with the narrow ID.
  typedef struct packed {
    out_id_t             id;
    logic [`ADDR_W-1:0]  addr;
    logic [`LEN_W-1:0]   len;
  } ax_dn_t;

  // Read data beats.
  typedef struct packed {
    in_id_t              id;
    logic [`DATA_W-1:0]  data;
    logic                last;
  } r_up_t;

  typedef struct packed {
    out_id_t             id;
    logic [`DATA_W-1:0]  data;
    logic                last;
  } r_dn_t;

  // Write responses.
  typedef struct packed {
    in_id_t              id;
    logic [1:0]          resp;
  } b_up_t;

  typedef struct packed {
    out_id_t             id;
    logic [1:0]          resp;
  } b_dn_t;

endpackage

`default_nettype wire

// File: id_remap_table.sv
// Remap table for one direction; maps output IDs back to input IDs and counts their transactions.
`default_nettype none

`include "id_remap_defs.svh"

module id_remap_table (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Lowest free output ID, valid only while the table is not full.
  output id_remap_pkg::out_id_t        free_id_o,
  output logic                         full_o,
  // Lookup of an upstream ID among the busy entries.
  input  wire id_remap_pkg::in_id_t    lookup_id_i,
  output logic                         hit_o,
  output id_remap_pkg::out_id_t        hit_id_o,
  output logic                         hit_full_o,
  // Allocation of one more transaction on an entry.
  input  wire logic                    push_i,
  input  wire id_remap_pkg::in_id_t    push_in_id_i,
  input  wire id_remap_pkg::out_id_t   push_out_id_i,
  // Retirement of one transaction, with the input ID of that entry returned.
  input  wire logic                    pop_i,
  input  wire id_remap_pkg::out_id_t   pop_out_id_i,
  output id_remap_pkg::in_id_t         pop_in_id_o
);

  import id_remap_pkg::*;

  // Returns the index of the lowest set bit.
  // The result is zero when no bit is set, so callers check the vector separately.
  function automatic out_id_t lowest_set(field_t bits);
    out_id_t idx;
    idx = '0;
    for (int i = `MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (bits[i]) begin
        idx = out_id_t'(i);
      end
    end
    return idx;
  endfunction

  // The table is indexed by output ID.
  entry_t [`MAX_UNIQ_IDS-1:0] table_q;
  entry_t [`MAX_UNIQ_IDS-1:0] table_d;

  // One bit per entry whose count is zero.
  field_t free;
  // One bit per busy entry that holds the looked-up input ID.
  field_t match;

  for (genvar i = 0; i < `MAX_UNIQ_IDS; i++) begin : gen_flags
    assign free[i]  = (table_q[i].cnt == '0);
    // A free entry may still carry an old input ID, so the count takes part in the match.
    assign match[i] = (table_q[i].cnt != '0) && (table_q[i].in_id == lookup_id_i);
  end

  // Free search.
  // Taking the lowest index keeps the downstream ID space dense.
  assign free_id_o = lowest_set(free);
  assign full_o    = ~|free;

  // Lookup.
  // At most one entry can match, so the lowest-bit search simply encodes it.
  assign hit_o      = |match;
  assign hit_id_o   = lowest_set(match);
  assign hit_full_o = (table_q[hit_id_o].cnt == cnt_t'(`MAX_TXNS_PER_ID));

  // The response side restores its ID straight from the entry it names.
  assign pop_in_id_o = table_q[pop_out_id_i].in_id;

  // Next table state.
  // A push and a pop in the same cycle may hit the same entry, in which case the count holds.
  always_comb begin
    table_d = table_q;
    if (push_i) begin
      table_d[push_out_id_i].in_id = push_in_id_i;
      table_d[push_out_id_i].cnt   = table_d[push_out_id_i].cnt + cnt_t'(1);
    end
    if (pop_i) begin
      table_d[pop_out_id_i].cnt = table_d[pop_out_id_i].cnt - cnt_t'(1);
    end
  end

  // After reset every count is zero, so every entry is free.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      table_q <= '0;
    end else begin
      table_q <= table_d;
    end
  end

  // The controller must only push to a free entry or to the one already owning the input ID.
  // Otherwise two input IDs would share an output ID and responses would be misrouted.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_i |-> (table_q[push_out_id_i].cnt == '0) ||
                 (table_q[push_out_id_i].in_id == push_in_id_i))
    else $error("Push to an entry owned by another input ID.");

  // The controller's admission check must keep every count within the limit.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_i |-> table_q[push_out_id_i].cnt < cnt_t'(`MAX_TXNS_PER_ID))
    else $error("Push beyond the per-ID in-flight limit.");

  // A response downstream must belong to a transaction that was issued.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      pop_i |-> table_q[pop_out_id_i].cnt != '0)
    else $error("Pop of an entry with no transaction in flight.");

  // Uniqueness of input IDs over time follows from the push rule above.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(match))
    else $error("Input ID found in more than one table entry.");

endmodule

`default_nettype wire

// File: id_remap_top.sv
// Top level of the AXI ID remapper; one controller for reads and one for writes.
`default_nettype none

module id_remap_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Upstream AR.
  input  wire id_remap_pkg::ax_up_t    ar_req_i,
  input  wire logic                    ar_valid_i,
  output logic                         ar_ready_o,
  // Upstream AW.
  input  wire id_remap_pkg::ax_up_t    aw_req_i,
  input  wire logic                    aw_valid_i,
  output logic                         aw_ready_o,
  // Upstream R.
  output id_remap_pkg::r_up_t          r_rsp_o,
  output logic                         r_valid_o,
  input  wire logic                    r_ready_i,
  // Upstream B.
  output id_remap_pkg::b_up_t          b_rsp_o,
  output logic                         b_valid_o,
  input  wire logic                    b_ready_i,
  // Downstream AR.
  output id_remap_pkg::ax_dn_t         ar_req_o,
  output logic                         ar_valid_o,
  input  wire logic                    ar_ready_i,
  // Downstream AW.
  output id_remap_pkg::ax_dn_t         aw_req_o,
  output logic                         aw_valid_o,
  input  wire logic                    aw_ready_i,
  // Downstream R.
  input  wire id_remap_pkg::r_dn_t     r_rsp_i,
  input  wire logic                    r_valid_i,
  output logic                         r_ready_o,
  // Downstream B.
  input  wire id_remap_pkg::b_dn_t     b_rsp_i,
  input  wire logic                    b_valid_i,
  output logic                         b_ready_o
);

  import id_remap_pkg::*;

  // Input IDs restored by each table.
  in_id_t rd_rsp_id;
  in_id_t wr_rsp_id;

  // Response handshakes pass straight through in both directions.
  assign r_valid_o = r_valid_i;
  assign r_ready_o = r_ready_i;
  assign b_valid_o = b_valid_i;
  assign b_ready_o = b_ready_i;

  // Only the ID of a response changes on its way up.
  assign r_rsp_o.id   = rd_rsp_id;
  assign r_rsp_o.data = r_rsp_i.data;
  assign r_rsp_o.last = r_rsp_i.last;
  assign b_rsp_o.id   = wr_rsp_id;
  assign b_rsp_o.resp = b_rsp_i.resp;

  // Read direction; a burst retires only on its last beat.
  id_remap_dir #(
    .RspHasLast ( 1'b1 )
  ) u_rd_dir (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .up_req_i       ( ar_req_i     ),
    .up_valid_i     ( ar_valid_i   ),
    .up_ready_o     ( ar_ready_o   ),
    .dn_req_o       ( ar_req_o     ),
    .dn_valid_o     ( ar_valid_o   ),
    .dn_ready_i     ( ar_ready_i   ),
    .dn_rsp_id_i    ( r_rsp_i.id   ),
    .dn_rsp_valid_i ( r_valid_i    ),
    .rsp_ready_i    ( r_ready_i    ),
    .rsp_last_i     ( r_rsp_i.last ),
    .up_rsp_id_o    ( rd_rsp_id    )
  );

  // Write direction; every B retires its entry, so the last input is tied high.
  id_remap_dir #(
    .RspHasLast ( 1'b0 )
  ) u_wr_dir (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .up_req_i       ( aw_req_i     ),
    .up_valid_i     ( aw_valid_i   ),
    .up_ready_o     ( aw_ready_o   ),
    .dn_req_o       ( aw_req_o     ),
    .dn_valid_o     ( aw_valid_o   ),
    .dn_ready_i     ( aw_ready_i   ),
    .dn_rsp_id_i    ( b_rsp_i.id   ),
    .dn_rsp_valid_i ( b_valid_i    ),
    .rsp_ready_i    ( b_ready_i    ),
    .rsp_last_i     ( 1'b1         ),
    .up_rsp_id_o    ( wr_rsp_id    )
  );

endmodule

`default_nettype wire

// File: id_remap_trace.txt
# Columns: op dir id addr n expected_id, with dir r or w and id, addr, expected_id in hex.
# I issue, P issue after n cycles of back-pressure, S stall n cycles, R respond (n is last).
I r 10 00001000 0 0
I r 11 00001040 0 1
I r 12 00001080 0 2
I r 13 000010c0 0 3
S r 14 00002000 5 0
R r 1 0 1 11
I r 14 00002000 0 1
R r 2 0 0 12
S r 15 00002040 3 0
R r 2 0 1 12
I r 15 00002040 0 2
R r 0 0 1 10
R r 1 0 1 14
R r 2 0 1 15
R r 3 0 1 13
I w 20 00003000 0 0
I w 20 00003100 0 0
I w 20 00003200 0 0
S w 20 00003300 4 0
R w 0 0 1 20
I w 20 00003300 0 0
P r 20 00004000 5 0
R w 0 0 1 20
R w 0 0 1 20
R w 0 0 1 20
I w 21 00003400 0 0
R r 0 0 1 20
I r 22 00004100 0 0

// File: run_sim.sh
#!/bin/sh
# Builds the ID remapper testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_id_remap -f id_remap.f

status=0
./obj_dir/Vtb_id_remap > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// File: tb_clk_gen.sv
// Clock and reset source for the ID remapper testbench; 4 ns clock, reset low for 10 cycles.
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  // Half of the 4 ns clock period.
  localparam int HalfPeriod  = 2;
  localparam int ResetCycles = 10;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Reset is released just after an edge, so the first active edge sees it settled.
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_id_remap.sv
// Testbench top for the ID remapper; replays id_remap_trace.txt against the DUT and checks it.
`default_nettype none

`include "id_remap_defs.svh"

module tb_id_remap;

  timeunit 1ns;
  timeprecision 100ps;

  import id_remap_pkg::*;

  // Longest wait for any handshake, in clock cycles.
  localparam int WaitLimit  = 200;
  // Inputs change this long after the rising edge.
  localparam int DriveDelay = 1;

  // Signals carry the DUT port names so that the instance connects by name.
  logic   clk_i;
  logic   rst_ni;
  ax_up_t ar_req_i;
  logic   ar_valid_i;
  logic   ar_ready_o;
  ax_up_t aw_req_i;
  logic   aw_valid_i;
  logic   aw_ready_o;
  r_up_t  r_rsp_o;
  logic   r_valid_o;
  logic   r_ready_i;
  b_up_t  b_rsp_o;
  logic   b_valid_o;
  logic   b_ready_i;
  ax_dn_t ar_req_o;
  logic   ar_valid_o;
  logic   ar_ready_i;
  ax_dn_t aw_req_o;
  logic   aw_valid_o;
  logic   aw_ready_i;
  r_dn_t  r_rsp_i;
  logic   r_valid_i;
  logic   r_ready_o;
  b_dn_t  b_rsp_i;
  logic   b_valid_i;
  logic   b_ready_o;

  // Errors of the operation in progress.
  int test_errors;
  bit timed_out;

  tb_clk_gen u_clk_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  id_remap_top UUT (.*);

  // Prints a wrong value with its time; called from the else branch of a check.
  task automatic report_fail(input string what);
    $display("Fail at %0t ns: %s", $time, what);
    test_errors++;
  endtask

  // Reads the request channel of one direction as it stands mid-cycle.
  task automatic sample_req(input bit wr, output logic up_rdy, output logic dn_vld,
                            output ax_dn_t dn);
    up_rdy = wr ? aw_ready_o : ar_ready_o;
    dn_vld = wr ? aw_valid_o : ar_valid_o;
    dn     = wr ? aw_req_o : ar_req_o;
  endtask

  // Mode I issues a request and waits for it, mode P first holds downstream ready low for
  // n cycles, and mode S expects a stall for n cycles and leaves the request pending.
  task automatic run_req(input logic [7:0] mode, input bit wr, input in_id_t id,
                         input logic [`ADDR_W-1:0] addr, input int n, input out_id_t exp_id);
    ax_up_t req;
    ax_dn_t dn;
    logic   up_rdy;
    logic   dn_vld;
    bit     seen;
    req.id   = id;
    req.addr = addr;
    req.len  = `LEN_W'($urandom());
    // A request left pending by a stall keeps its payload until it is taken.
    if (wr && !aw_valid_i) begin
      aw_req_i   = req;
      aw_valid_i = 1'b1;
    end else if (!wr && !ar_valid_i) begin
      ar_req_i   = req;
      ar_valid_i = 1'b1;
    end
    req        = wr ? aw_req_i : ar_req_i;
    ar_ready_i = !(mode == "P" && !wr);
    aw_ready_i = !(mode == "P" && wr);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      sample_req(wr, up_rdy, dn_vld, dn);
      if (mode == "S") begin
        assert (!up_rdy && !dn_vld)
          else report_fail($sformatf("no stall, ready %b valid %b", up_rdy, dn_vld));
      end else begin
        assert (dn_vld && !up_rdy && dn.id == exp_id)
          else report_fail($sformatf("held request valid %b ready %b id %0d, expected id %0d",
                                     dn_vld, up_rdy, dn.id, exp_id));
      end
      @(posedge clk_i);
    end
    if (n > 0) begin
      #DriveDelay;
      ar_ready_i = 1'b1;
      aw_ready_i = 1'b1;
    end
    if (mode != "S") begin
      seen = 1'b0;
      for (int i = 0; i < WaitLimit && !seen; i++) begin
        @(negedge clk_i);
        sample_req(wr, up_rdy, dn_vld, dn);
        seen = up_rdy;
      end
      if (!seen) begin
        $display("Timeout: request with input ID %h was not accepted in %0d cycles",
                 id, WaitLimit);
        test_errors++;
        timed_out = 1'b1;
      end else begin
        assert (dn_vld && dn.id == exp_id)
          else report_fail($sformatf("output ID %0d valid %b, expected ID %0d",
                                     dn.id, dn_vld, exp_id));
        assert (dn.addr == req.addr && dn.len == req.len)
          else report_fail($sformatf("address %h length %0d, expected %h and %0d",
                                     dn.addr, dn.len, req.addr, req.len));
        @(posedge clk_i);
        #DriveDelay;
        ar_valid_i = 1'b0;
        aw_valid_i = 1'b0;
      end
    end
  endtask

  // Returns one response downstream; it reaches upstream within the same cycle.
  task automatic run_rsp(input bit wr, input out_id_t id, input bit last, input in_id_t exp_id);
    logic [`DATA_W-1:0] data;
    logic [1:0]         resp;
    data = `DATA_W'($urandom());
    resp = 2'($urandom());
    if (wr) begin
      b_rsp_i   = '{id: id, resp: resp};
      b_valid_i = 1'b1;
    end else begin
      r_rsp_i   = '{id: id, data: data, last: last};
      r_valid_i = 1'b1;
    end
    @(negedge clk_i);
    if (wr) begin
      assert (b_valid_o && b_ready_o && b_rsp_o.id == exp_id && b_rsp_o.resp == resp)
        else report_fail($sformatf("B id %h resp %0d, expected id %h resp %0d",
                                   b_rsp_o.id, b_rsp_o.resp, exp_id, resp));
    end else begin
      assert (r_valid_o && r_ready_o && r_rsp_o.id == exp_id && r_rsp_o.data == data &&
              r_rsp_o.last == last)
        else report_fail($sformatf("R id %h data %h last %b, expected id %h data %h last %b",
                                   r_rsp_o.id, r_rsp_o.data, r_rsp_o.last, exp_id, data, last));
    end
    @(posedge clk_i);
    #DriveDelay;
    r_valid_i = 1'b0;
    b_valid_i = 1'b0;
  endtask

  initial begin
    int                  fd;
    int                  code;
    int                  tests;
    int                  failed;
    logic [7:0]          op;
    logic [7:0]          dir;
    in_id_t              id;
    logic [`ADDR_W-1:0]  addr;
    int                  num;
    in_id_t              exp_id;
    logic [8*128-1:0]    line;
    ar_req_i    = '0;
    ar_valid_i  = 1'b0;
    aw_req_i    = '0;
    aw_valid_i  = 1'b0;
    r_ready_i   = 1'b1;
    b_ready_i   = 1'b1;
    ar_ready_i  = 1'b1;
    aw_ready_i  = 1'b1;
    r_rsp_i     = '0;
    r_valid_i   = 1'b0;
    b_rsp_i     = '0;
    b_valid_i   = 1'b0;
    tests       = 0;
    failed      = 0;
    test_errors = 0;
    timed_out   = 1'b0;
    void'($urandom(42));
    fd = $fopen("id_remap_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file id_remap_trace.txt");
      failed++;
    end
    for (int i = 0; i < WaitLimit && !rst_ni; i++) begin
      @(posedge clk_i);
    end
    if (!rst_ni) begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end
    @(posedge clk_i);
    #DriveDelay;
    // Each trace line is one operation and counts as one test.
    while (fd != 0 && !timed_out && $fscanf(fd, " %s", op) == 1) begin
      if (op == "#") begin
        code = $fgets(line, fd);
        continue;
      end
      code        = $fscanf(fd, " %s %h %h %d %h", dir, id, addr, num, exp_id);
      test_errors = 0;
      tests++;
      if (code != 5) begin
        $display("Malformed trace line for operation %s", op);
        test_errors++;
      end else if (op == "R") begin
        run_rsp(dir == "w", out_id_t'(id), num[0], exp_id);
      end else if (op == "I" || op == "P" || op == "S") begin
        run_req(op, dir == "w", id, addr, num, out_id_t'(exp_id));
      end else begin
        $display("Unknown trace operation %s", op);
        test_errors++;
      end
      if (test_errors == 0) begin
        $display("Test %0d (%s %s %h) passed", tests, op, dir, id);
      end else begin
        $display("Test %0d (%s %s %h) failed with %0d errors", tests, op, dir, id, test_errors);
        failed++;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("%0d tests run, %0d passed, %0d failed", tests, tests - failed, failed);
    if (failed == 0 && tests > 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
